/* bd_arbiter.sv */
`timescale 1ns/1ps
// Round-robin arbiter for the single-port BD memory. The grant is combinational.
module bd_arbiter #(
   parameter int BD_ADDR_W = 8
) (
   input  logic                 clk_i,
   input  logic                 arst_i,
   bd_port_if.arbiter           tx_bd,
   bd_port_if.arbiter           rx_bd,
   output logic [BD_ADDR_W-1:0] bd_addr_o,
   output logic                 bd_wen_o,
   output logic [31:0]          bd_wdata_o
);

   logic last_rx_q;
   logic tx_win;
   logic rx_win;

   // On a tie, the engine that was not served last wins
   assign tx_win = tx_bd.req && (!rx_bd.req || last_rx_q);
   assign rx_win = rx_bd.req && !tx_win;

   assign tx_bd.grant = tx_win;
   assign rx_bd.grant = rx_win;

   // Steer the winner onto the memory port
   assign bd_addr_o  = rx_win ? rx_bd.addr : tx_bd.addr;
   assign bd_wen_o   = rx_win ? rx_bd.wen : (tx_win && tx_bd.wen);
   assign bd_wdata_o = rx_win ? rx_bd.wdata : tx_bd.wdata;

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         last_rx_q <= 1'b1;
      end else if (tx_win || rx_win) begin
         last_rx_q <= rx_win;
      end
   end

endmodule

/* bd_port_if.sv */
`timescale 1ns/1ps
// One engine's port onto the shared BD memory. Hold req and addr until grant.
// Read data follows one cycle after grant, and a write lands in the granted cycle.
interface bd_port_if #(
   parameter int BD_ADDR_W = 8
);
   logic                 req;
   logic [BD_ADDR_W-1:0] addr;
   logic                 wen;
   logic [31:0]          wdata;
   logic                 grant;

   modport engine (
      output req, addr, wen, wdata,
      input  grant
   );

   modport arbiter (
      input  req, addr, wen, wdata,
      output grant
   );

endinterface

/* eth_dma.sv */
`timescale 1ns/1ps
// Ethernet frame DMA top. The AXI side must assume byte-size INCR bursts.
// No B channel is present, so the write response is always taken.
module eth_dma #(
   parameter int AXI_ADDR_W = 16,
   parameter int BD_ADDR_W  = 8,
   parameter int BUFFER_W   = 11
) (
   input  logic                                 clk_i,
   input  logic                                 arst_i,
   input  logic                                 tx_en_i,
   input  logic                                 rx_en_i,
   input  logic [BD_ADDR_W-2:0]                 tx_bd_num_i,
   // BD memory
   output logic [BD_ADDR_W-1:0]                 bd_addr_o,
   output logic                                 bd_wen_o,
   output logic [31:0]                          bd_wdata_o,
   input  logic [31:0]                          bd_rdata_i,
   // Transmit buffer and MAC
   output logic                                 tx_buf_wen_o,
   output logic [BUFFER_W-1:0]                  tx_buf_addr_o,
   output logic [7:0]                           tx_buf_wdata_o,
   input  logic                                 tx_ready_i,
   output logic                                 crc_en_o,
   output logic [eth_dma_pkg::NBYTES_W-1:0]     tx_nbytes_o,
   output logic                                 send_o,
   // Receive buffer and MAC
   output logic [BUFFER_W-1:0]                  rx_buf_addr_o,
   input  logic [7:0]                           rx_buf_rdata_i,
   input  logic                                 rx_data_rcvd_i,
   input  logic                                 crc_err_i,
   input  logic [eth_dma_pkg::NBYTES_W-1:0]     rx_nbytes_i,
   output logic                                 rcv_ack_o,
   // AXI read
   output logic [AXI_ADDR_W-1:0]                araddr_o,
   output logic [eth_dma_pkg::AXI_LEN_W-1:0]    arlen_o,
   output logic                                 arvalid_o,
   input  logic                                 arready_i,
   input  logic [eth_dma_pkg::AXI_DATA_W-1:0]   rdata_i,
   input  logic                                 rvalid_i,
   output logic                                 rready_o,
   input  logic                                 rlast_i,
   // AXI write
   output logic [AXI_ADDR_W-1:0]                awaddr_o,
   output logic [eth_dma_pkg::AXI_LEN_W-1:0]    awlen_o,
   output logic                                 awvalid_o,
   input  logic                                 awready_i,
   output logic [eth_dma_pkg::AXI_DATA_W-1:0]   wdata_o,
   output logic [eth_dma_pkg::AXI_DATA_W/8-1:0] wstrb_o,
   output logic                                 wvalid_o,
   input  logic                                 wready_i,
   output logic                                 wlast_o,
   output logic                                 tx_irq_o,
   output logic                                 rx_irq_o
);

   bd_port_if #(.BD_ADDR_W(BD_ADDR_W)) tx_bd ();
   bd_port_if #(.BD_ADDR_W(BD_ADDR_W)) rx_bd ();

   eth_dma_tx #(
      .AXI_ADDR_W(AXI_ADDR_W),
      .BD_ADDR_W (BD_ADDR_W),
      .BUFFER_W  (BUFFER_W)
   ) tx_i (
      .clk_i, .arst_i, .tx_en_i, .tx_ready_i, .bd_rdata_i,
      .bd(tx_bd.engine),
      .araddr_o, .arlen_o, .arvalid_o, .arready_i,
      .rvalid_i, .rdata_i, .rlast_i, .rready_o,
      .tx_buf_wen_o, .tx_buf_addr_o, .tx_buf_wdata_o,
      .crc_en_o, .tx_nbytes_o, .send_o, .tx_irq_o
   );

   eth_dma_rx #(
      .AXI_ADDR_W(AXI_ADDR_W),
      .BD_ADDR_W (BD_ADDR_W),
      .BUFFER_W  (BUFFER_W)
   ) rx_i (
      .clk_i, .arst_i, .rx_en_i, .tx_bd_num_i,
      .rx_data_rcvd_i, .crc_err_i, .rx_nbytes_i,
      .rx_buf_addr_o, .rx_buf_rdata_i, .bd_rdata_i,
      .bd(rx_bd.engine),
      .awaddr_o, .awlen_o, .awvalid_o, .awready_i,
      .wdata_o, .wstrb_o, .wvalid_o, .wlast_o, .wready_i,
      .rcv_ack_o, .rx_irq_o
   );

   bd_arbiter #(
      .BD_ADDR_W(BD_ADDR_W)
   ) arb_i (
      .clk_i, .arst_i,
      .tx_bd(tx_bd.arbiter),
      .rx_bd(rx_bd.arbiter),
      .bd_addr_o, .bd_wen_o, .bd_wdata_o
   );

endmodule

/* eth_dma_checker.sv */
`timescale 1ns/1ps
// AXI and BD protocol assertions, bound to every eth_dma instance
module eth_dma_checker (
   input logic                                 clk_i,
   input logic                                 arst_i,
   input logic                                 arvalid_o,
   input logic                                 arready_i,
   input logic [eth_dma_pkg::AXI_LEN_W-1:0]    arlen_o,
   input logic                                 awvalid_o,
   input logic [eth_dma_pkg::AXI_LEN_W-1:0]    awlen_o,
   input logic                                 wvalid_o,
   input logic [eth_dma_pkg::AXI_DATA_W/8-1:0] wstrb_o,
   input logic                                 bd_wen_o,
   input logic                                 bd_addr_lsb_i,
   input logic [31:0]                          bd_wdata_o
);

   eth_dma_pkg::bd_status_u wr_status;
   // Number of failed assertions
   int                      fail_cnt = 0;

   assign wr_status = bd_wdata_o;

   assert property (@(posedge clk_i) disable iff (arst_i)
      arvalid_o |-> arlen_o <= 8'd15)
   else begin
      $error("arlen above 15");
      fail_cnt++;
   end
   assert property (@(posedge clk_i) disable iff (arst_i)
      awvalid_o |-> awlen_o <= 8'd15)
   else begin
      $error("awlen above 15");
      fail_cnt++;
   end
   assert property (@(posedge clk_i) disable iff (arst_i)
      wvalid_o |-> $onehot(wstrb_o))
   else begin
      $error("wstrb not one-hot");
      fail_cnt++;
   end
   assert property (@(posedge clk_i) disable iff (arst_i)
      arvalid_o && !arready_i |=> arvalid_o)
   else begin
      $error("arvalid dropped early");
      fail_cnt++;
   end
   // Status write-back always hands the BD back to software
   assert property (@(posedge clk_i) disable iff (arst_i)
      bd_wen_o && !bd_addr_lsb_i |-> !wr_status.tx.ready)
   else begin
      $error("ready left set");
      fail_cnt++;
   end

endmodule

bind eth_dma eth_dma_checker chk_i (
   .clk_i(clk_i), .arst_i(arst_i), .arvalid_o(arvalid_o), .arready_i(arready_i),
   .arlen_o(arlen_o), .awvalid_o(awvalid_o), .awlen_o(awlen_o), .wvalid_o(wvalid_o),
   .wstrb_o(wstrb_o), .bd_wen_o(bd_wen_o), .bd_addr_lsb_i(bd_addr_o[0]),
   .bd_wdata_o(bd_wdata_o)
);

/* eth_dma_pkg.sv */
// Constants shared by the DMA engines and the layout of BD word 0.
// Only byte-size INCR bursts on a 32-bit AXI bus are supported.
package eth_dma_pkg;

   localparam int AXI_DATA_W    = 32;
   localparam int AXI_LEN_W     = 8;
   localparam int MAX_BURST_LEN = 16;
   localparam int NBYTES_W      = 11;

   // Preamble and SFD sit at the start of the transmit buffer
   localparam int         PREAMBLE_LEN  = 7;
   localparam logic [7:0] PREAMBLE_BYTE = 8'h55;
   localparam logic [7:0] SFD_BYTE      = 8'hD5;
   localparam int         PRE_FRAME_LEN = PREAMBLE_LEN + 1;

   localparam int BD_READY_BIT = 15;
   localparam int BD_IRQ_BIT   = 14;
   localparam int BD_WRAP_BIT  = 13;

   // BD word 0, seen by either engine
   typedef union packed {
      struct packed {
         logic [15:0] length;
         logic        ready;
         logic        irq;
         logic        wrap;
         logic        rsvd_12;
         logic        crc_en;
         logic [10:0] rsvd;
      } tx;
      struct packed {
         logic [15:0] length;
         logic        ready;
         logic        irq;
         logic        wrap;
         logic [10:0] rsvd;
         logic        crc_err;
         logic        rsvd_0;
      } rx;
   } bd_status_u;

   // AXI len field for the next burst, capped at 16 beats
   function automatic logic [AXI_LEN_W-1:0] burst_len(input logic [NBYTES_W-1:0] remaining);
      logic [NBYTES_W-1:0] beats;
      if (remaining > NBYTES_W'(MAX_BURST_LEN)) begin
         beats = NBYTES_W'(MAX_BURST_LEN);
      end else begin
         beats = remaining;
      end
      return AXI_LEN_W'(beats - 1'b1);
   endfunction

endpackage

/* eth_dma_rx.sv */
`timescale 1ns/1ps
// Receive DMA. Write bursts must not cross a 4 KB boundary, and B responses are ignored.
// The ring runs from tx_bd_num_i up to the last BD index.
module eth_dma_rx #(
   parameter int AXI_ADDR_W = 16,
   parameter int BD_ADDR_W  = 8,
   parameter int BUFFER_W   = 11
) (
   input  logic                                 clk_i,
   input  logic                                 arst_i,
   input  logic                                 rx_en_i,
   input  logic [BD_ADDR_W-2:0]                 tx_bd_num_i,
   input  logic                                 rx_data_rcvd_i,
   input  logic                                 crc_err_i,
   input  logic [eth_dma_pkg::NBYTES_W-1:0]     rx_nbytes_i,
   output logic [BUFFER_W-1:0]                  rx_buf_addr_o,
   input  logic [7:0]                           rx_buf_rdata_i,
   input  logic [31:0]                          bd_rdata_i,
   bd_port_if.engine                            bd,
   output logic [AXI_ADDR_W-1:0]                awaddr_o,
   output logic [eth_dma_pkg::AXI_LEN_W-1:0]    awlen_o,
   output logic                                 awvalid_o,
   input  logic                                 awready_i,
   output logic [eth_dma_pkg::AXI_DATA_W-1:0]   wdata_o,
   output logic [eth_dma_pkg::AXI_DATA_W/8-1:0] wstrb_o,
   output logic                                 wvalid_o,
   output logic                                 wlast_o,
   input  logic                                 wready_i,
   output logic                                 rcv_ack_o,
   output logic                                 rx_irq_o
);

   localparam int NB_W   = eth_dma_pkg::NBYTES_W;
   localparam int STRB_W = eth_dma_pkg::AXI_DATA_W / 8;

   localparam logic [3:0] S_BD_REQ   = 4'd0;
   localparam logic [3:0] S_BD_CHK   = 4'd1;
   localparam logic [3:0] S_PTR_REQ  = 4'd2;
   localparam logic [3:0] S_PTR_RD   = 4'd3;
   localparam logic [3:0] S_MAC_WAIT = 4'd4;
   localparam logic [3:0] S_FETCH    = 4'd5;
   localparam logic [3:0] S_AW       = 4'd6;
   localparam logic [3:0] S_WR       = 4'd7;
   localparam logic [3:0] S_ACK      = 4'd8;
   localparam logic [3:0] S_WB       = 4'd9;

   logic [3:0]                        state_q;
   logic [BD_ADDR_W-2:0]              bd_num_q;
   logic [NB_W-1:0]                   cnt_q;
   logic [eth_dma_pkg::AXI_LEN_W-1:0] beat_q;
   eth_dma_pkg::bd_status_u           desc_q;
   eth_dma_pkg::bd_status_u           rd_status;
   logic [AXI_ADDR_W-1:0]             ptr_q;
   logic [NB_W-1:0]                   remaining;
   logic [1:0]                        lane;
   logic                              beat;

   assign rd_status = bd_rdata_i;
   assign remaining = rx_nbytes_i - cnt_q;
   assign lane      = ptr_q[1:0] + cnt_q[1:0];
   assign beat      = wvalid_o && wready_i;

   // Buffer read is synchronous, so fetch the next byte as a beat is taken
   assign rx_buf_addr_o = BUFFER_W'(beat ? cnt_q + 1'b1 : cnt_q);

   assign bd.req   = (state_q == S_BD_REQ) || (state_q == S_PTR_REQ) || (state_q == S_WB);
   assign bd.addr  = {bd_num_q, state_q == S_PTR_REQ};
   assign bd.wen   = (state_q == S_WB);
   assign bd.wdata = desc_q;
   assign rx_irq_o = (state_q == S_WB) && bd.grant && desc_q.rx.irq;

   assign awaddr_o  = ptr_q + AXI_ADDR_W'(cnt_q);
   assign awvalid_o = (state_q == S_AW);
   assign wvalid_o  = (state_q == S_WR);
   assign wlast_o   = wvalid_o && (beat_q == awlen_o);
   assign wstrb_o   = STRB_W'(1) << lane;
   // The byte is copied to every lane and wstrb picks the live one
   assign wdata_o   = {STRB_W{rx_buf_rdata_i}};

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q   <= S_BD_REQ;
         bd_num_q  <= tx_bd_num_i;
         cnt_q     <= '0;
         beat_q    <= '0;
         rcv_ack_o <= 1'b0;
      end else begin
         case (state_q)
            S_BD_REQ: if (bd.grant) state_q <= S_BD_CHK;
            S_BD_CHK: begin
               desc_q  <= rd_status;
               state_q <= (rd_status.rx.ready && rx_en_i) ? S_PTR_REQ : S_BD_REQ;
            end
            S_PTR_REQ: if (bd.grant) state_q <= S_PTR_RD;
            S_PTR_RD: begin
               ptr_q   <= bd_rdata_i[AXI_ADDR_W-1:0];
               cnt_q   <= '0;
               state_q <= S_MAC_WAIT;
            end
            S_MAC_WAIT: if (rx_data_rcvd_i) state_q <= S_FETCH;
            S_FETCH: begin
               if (remaining == '0) begin
                  // Frame copied, build the status word
                  desc_q.rx.length  <= 16'(rx_nbytes_i);
                  desc_q.rx.crc_err <= crc_err_i;
                  desc_q.rx.ready   <= 1'b0;
                  rcv_ack_o         <= 1'b1;
                  state_q           <= S_ACK;
               end else begin
                  awlen_o <= eth_dma_pkg::burst_len(remaining);
                  beat_q  <= '0;
                  state_q <= S_AW;
               end
            end
            S_AW: if (awready_i) state_q <= S_WR;
            S_WR: if (wready_i) begin
               cnt_q  <= cnt_q + 1'b1;
               beat_q <= beat_q + 1'b1;
               if (wlast_o) state_q <= S_FETCH;
            end
            S_ACK: if (!rx_data_rcvd_i) begin
               rcv_ack_o <= 1'b0;
               state_q   <= S_WB;
            end
            S_WB: if (bd.grant) begin
               bd_num_q <= (desc_q.rx.wrap || &bd_num_q) ? tx_bd_num_i : bd_num_q + 1'b1;
               state_q  <= S_BD_REQ;
            end
            default: state_q <= S_BD_REQ;
         endcase
      end
   end

endmodule

/* eth_dma_tb.sv */
`timescale 1ns/1ps
// Directed tests of eth_dma with behavioral BD memory, AXI memory and buffers.
// BD n has word 0 at address 2n and its pointer at 2n+1.
module eth_dma_tb;

   localparam int TMO = 3000;

   logic clk, arst, tx_en_i, rx_en_i, tx_ready_i, rx_data_rcvd_i, crc_err_i;
   logic [6:0]  tx_bd_num_i;
   logic [7:0]  bd_addr_o, tx_buf_wdata_o, rx_buf_rdata_i;
   logic        bd_wen_o, tx_buf_wen_o, crc_en_o, send_o, rcv_ack_o, tx_irq_o, rx_irq_o;
   logic [31:0] bd_wdata_o, bd_rdata_i, rdata_i, wdata_o;
   logic [10:0] tx_buf_addr_o, rx_buf_addr_o, tx_nbytes_o, rx_nbytes_i;
   logic [15:0] araddr_o, awaddr_o;
   logic [7:0]  arlen_o, awlen_o;
   logic        arvalid_o, arready_i, rvalid_i, rready_o, rlast_i;
   logic        awvalid_o, awready_i, wvalid_o, wready_i, wlast_o;
   logic [3:0]  wstrb_o;

   logic [31:0] bd_mem [256];
   logic [7:0]  amem [65536];
   logic [7:0]  tx_buf [2048];
   logic [7:0]  rx_buf [2048];
   logic [7:0]  bd_raddr;
   logic [10:0] rxb_raddr;
   logic [15:0] rd_addr, wr_addr;
   int          rd_left, wr_left, ar_cnt, tx_irq_cnt, rx_irq_cnt, errors, tests, k;
   logic        r_taken, saw_bd0;
   integer      seed = 32'h5765_279b;

   tb_clk_gen clk_gen_i (.clk_o(clk), .arst_o(arst));

   eth_dma #(.AXI_ADDR_W(16), .BD_ADDR_W(8), .BUFFER_W(11)) dut_i (
      .clk_i(clk), .arst_i(arst), .tx_en_i, .rx_en_i, .tx_bd_num_i,
      .bd_addr_o, .bd_wen_o, .bd_wdata_o, .bd_rdata_i,
      .tx_buf_wen_o, .tx_buf_addr_o, .tx_buf_wdata_o, .tx_ready_i, .crc_en_o,
      .tx_nbytes_o, .send_o, .rx_buf_addr_o, .rx_buf_rdata_i, .rx_data_rcvd_i,
      .crc_err_i, .rx_nbytes_i, .rcv_ack_o,
      .araddr_o, .arlen_o, .arvalid_o, .arready_i, .rdata_i, .rvalid_i, .rready_o, .rlast_i,
      .awaddr_o, .awlen_o, .awvalid_o, .awready_i, .wdata_o, .wstrb_o, .wvalid_o,
      .wready_i, .wlast_o, .tx_irq_o, .rx_irq_o
   );

   // Models take DUT requests on the rising edge
   always @(posedge clk) begin
      if (bd_wen_o) bd_mem[bd_addr_o] = bd_wdata_o;
      bd_raddr  = bd_addr_o;
      rxb_raddr = rx_buf_addr_o;
      if (tx_buf_wen_o) tx_buf[tx_buf_addr_o] = tx_buf_wdata_o;
      if (arvalid_o && arready_i) begin
         rd_addr = araddr_o;
         rd_left = arlen_o + 1;
         ar_cnt++;
      end
      if (rvalid_i && rready_o) begin
         rd_addr++;
         rd_left--;
         r_taken = 1'b1;
      end
      if (awvalid_o && awready_i) begin
         wr_addr = awaddr_o;
         wr_left = awlen_o + 1;
      end
      if (wvalid_o && wready_i) begin
         check_bit("wlast_o", wlast_o, wr_left == 1);
         // Only the strobed lanes reach memory
         for (int j = 0; j < 4; j++) begin
            if (wstrb_o[j]) amem[{wr_addr[15:2], 2'(j)}] = wdata_o[j*8 +: 8];
         end
         wr_addr++;
         wr_left--;
      end
      if (tx_irq_o) tx_irq_cnt++;
      if (rx_irq_o) rx_irq_cnt++;
      if (bd_addr_o == 8'd0) saw_bd0 = 1'b1;
   end

   // Responses and random back-pressure go out on the falling edge
   always @(negedge clk) begin
      bd_rdata_i     = bd_mem[bd_raddr];
      rx_buf_rdata_i = rx_buf[rxb_raddr];
      arready_i      = arvalid_o && ($random(seed) & 1);
      awready_i      = awvalid_o && ($random(seed) & 1);
      wready_i       = wvalid_o && (($random(seed) & 3) != 0);
      if (r_taken || !rvalid_i) begin
         r_taken = 1'b0;
         rvalid_i = (rd_left != 0) && (($random(seed) & 3) != 0);
         rlast_i  = rvalid_i && (rd_left == 1);
         for (k = 0; k < 4; k++) rdata_i[k*8 +: 8] = amem[{rd_addr[15:2], 2'(k)}];
      end
   end

   task automatic check_byte(string name, logic [7:0] got, logic [7:0] exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_status(string name, eth_dma_pkg::bd_status_u got,
                               eth_dma_pkg::bd_status_u exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %h expected %h", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_count(string name, int got, int exp);
      if (got != exp) begin
         $display("ERR %0t %s got %0d expected %0d", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic check_bit(string name, logic got, logic exp);
      if (got !== exp) begin
         $display("ERR %0t %s got %b expected %b", $time, name, got, exp);
         errors++;
      end
   endtask

   task automatic report_timeout(string what);
      $display("Timeout while waiting for %s", what);
      errors++;
   endtask

   task automatic finish_test(string name, int errors_before);
      tests++;
      $display("%s: %0d errors", name, errors - errors_before);
   endtask

   task automatic set_bd(int idx, eth_dma_pkg::bd_status_u st, logic [31:0] ptr);
      bd_mem[2*idx+1] = ptr;
      bd_mem[2*idx]   = st;
   endtask

   task automatic check_tx_frame(logic [15:0] ptr, int len);
      for (int i = 0; i < len; i++) check_byte("tx_buf", tx_buf[8+i], amem[16'(ptr+i)]);
      check_count("tx_nbytes_o", int'(tx_nbytes_o), len + 8);
   endtask

   task automatic check_rx_frame(logic [15:0] ptr, int len);
      for (int i = 0; i < len; i++) check_byte("amem", amem[16'(ptr+i)], rx_buf[i]);
   endtask

   // Sends the frame of a ready transmit BD and waits for its write-back
   task automatic run_tx(int idx, logic [15:0] ptr, int len, logic crc);
      eth_dma_pkg::bd_status_u st;
      int n;
      tx_ready_i = 1'b1;
      for (n = 0; n < TMO && !send_o; n++) @(negedge clk);
      if (!send_o) report_timeout("send_o");
      check_tx_frame(ptr, len);
      check_bit("crc_en_o", crc_en_o, crc);
      repeat (3) @(negedge clk);
      check_bit("send_o", send_o, 1'b1);
      tx_ready_i = 1'b0;
      st = bd_mem[2*idx];
      for (n = 0; n < TMO && st.tx.ready; n++) begin
         @(negedge clk);
         st = bd_mem[2*idx];
      end
      if (st.tx.ready) report_timeout("transmit write-back");
      check_bit("send_o", send_o, 1'b0);
   endtask

   task automatic test_preamble();
      int e = errors;
      // Fill runs for exactly 8 cycles after reset
      repeat (10) @(negedge clk);
      for (int i = 0; i < 7; i++) check_byte("tx_buf", tx_buf[i], 8'h55);
      check_byte("tx_buf[7]", tx_buf[7], 8'hD5);
      check_bit("send_o", send_o, 1'b0);
      check_bit("tx_irq_o", tx_irq_o, 1'b0);
      check_bit("rx_irq_o", rx_irq_o, 1'b0);
      finish_test("preamble fill", e);
   endtask

   task automatic test_tx_frame();
      eth_dma_pkg::bd_status_u st;
      int e = errors;
      st = '0;
      st.tx.length = 16'd37;
      st.tx.ready  = 1'b1;
      st.tx.irq    = 1'b1;
      st.tx.crc_en = 1'b1;
      set_bd(0, st, 32'h0103);
      tx_en_i = 1'b1;
      run_tx(0, 16'h0103, 37, 1'b1);
      st.tx.ready = 1'b0;
      check_status("bd word 0", bd_mem[0], st);
      check_count("tx_irq pulses", tx_irq_cnt, 1);
      finish_test("transmit frame", e);
   endtask

   task automatic test_tx_ring();
      eth_dma_pkg::bd_status_u st;
      int e = errors;
      int n;
      int ar_before;
      st = '0;
      st.tx.length = 16'd5;
      st.tx.ready  = 1'b1;
      st[eth_dma_pkg::BD_WRAP_BIT] = 1'b1;
      set_bd(1, st, 32'h0200);
      run_tx(1, 16'h0200, 5, 1'b0);
      saw_bd0 = 1'b0;
      for (n = 0; n < TMO && !saw_bd0; n++) @(negedge clk);
      if (!saw_bd0) report_timeout("fetch of BD 0 after wrap");
      tx_en_i = 1'b0;
      st.tx.wrap = 1'b0;
      set_bd(0, st, 32'h0300);
      tx_ready_i = 1'b1;
      ar_before = ar_cnt;
      for (n = 0; n < 100 && !arvalid_o; n++) @(negedge clk);
      if (arvalid_o) begin
         $display("Read burst started while transmit was disabled");
         errors++;
      end
      check_count("read bursts", ar_cnt, ar_before);
      tx_ready_i = 1'b0;
      finish_test("transmit ring", e);
   endtask

   task automatic test_rx_frame();
      eth_dma_pkg::bd_status_u st;
      int e = errors;
      int n;
      for (int i = 0; i < 2048; i++) rx_buf[i] = 8'(i * 13 + 5) ^ 8'(i >> 8);
      st = '0;
      st.rx.ready = 1'b1;
      st[eth_dma_pkg::BD_IRQ_BIT] = 1'b1;
      set_bd(64, st, 32'h0302);
      rx_nbytes_i    = 11'd21;
      crc_err_i      = 1'b1;
      rx_en_i        = 1'b1;
      rx_data_rcvd_i = 1'b1;
      for (n = 0; n < TMO && !rcv_ack_o; n++) @(negedge clk);
      if (!rcv_ack_o) report_timeout("rcv_ack_o");
      check_rx_frame(16'h0302, 21);
      repeat (3) @(negedge clk);
      check_bit("rcv_ack_o", rcv_ack_o, 1'b1);
      rx_data_rcvd_i = 1'b0;
      for (n = 0; n < TMO && bd_mem[128][eth_dma_pkg::BD_READY_BIT]; n++) @(negedge clk);
      if (bd_mem[128][eth_dma_pkg::BD_READY_BIT]) report_timeout("receive write-back");
      check_bit("rcv_ack_o", rcv_ack_o, 1'b0);
      st.rx.ready   = 1'b0;
      st.rx.length  = 16'd21;
      st.rx.crc_err = 1'b1;
      check_status("bd word 0", bd_mem[128], st);
      check_count("rx_irq pulses", rx_irq_cnt, 1);
      finish_test("receive frame", e);
   endtask

   task automatic test_concurrent();
      eth_dma_pkg::bd_status_u tx_st, rx_st;
      int e = errors;
      int n;
      logic tx_done, rx_done;
      for (int i = 0; i < 2048; i++) rx_buf[i] = 8'(i * 7 + 99) ^ 8'(i >> 8);
      tx_st = '0;
      tx_st.tx.length = 16'd30;
      tx_st.tx.ready  = 1'b1;
      tx_st.tx.irq    = 1'b1;
      set_bd(0, tx_st, 32'h0411);
      rx_st = '0;
      rx_st.rx.ready = 1'b1;
      rx_st.rx.irq   = 1'b1;
      set_bd(65, rx_st, 32'h0522);
      rx_nbytes_i    = 11'd19;
      crc_err_i      = 1'b0;
      tx_en_i        = 1'b1;
      tx_ready_i     = 1'b1;
      rx_data_rcvd_i = 1'b1;
      tx_done = 1'b0;
      rx_done = 1'b0;
      for (n = 0; n < TMO && !(tx_done && rx_done); n++) begin
         @(negedge clk);
         if (send_o && tx_ready_i) begin
            check_tx_frame(16'h0411, 30);
            check_bit("crc_en_o", crc_en_o, 1'b0);
            tx_ready_i = 1'b0;
         end
         if (rcv_ack_o && rx_data_rcvd_i) begin
            check_rx_frame(16'h0522, 19);
            rx_data_rcvd_i = 1'b0;
         end
         tx_done = !tx_ready_i && !bd_mem[0][eth_dma_pkg::BD_READY_BIT];
         rx_done = !rx_data_rcvd_i && !bd_mem[130][eth_dma_pkg::BD_READY_BIT];
      end
      if (!(tx_done && rx_done)) report_timeout("both frames");
      tx_st.tx.ready = 1'b0;
      rx_st.rx.ready  = 1'b0;
      rx_st.rx.length = 16'd19;
      check_status("tx bd word 0", bd_mem[0], tx_st);
      check_status("rx bd word 0", bd_mem[130], rx_st);
      check_count("tx_irq pulses", tx_irq_cnt, 2);
      check_count("rx_irq pulses", rx_irq_cnt, 2);
      finish_test("concurrent traffic", e);
   endtask

   initial begin
      tx_en_i = 1'b0;
      rx_en_i = 1'b0;
      tx_bd_num_i = 7'd64;
      tx_ready_i = 1'b0;
      rx_data_rcvd_i = 1'b0;
      crc_err_i = 1'b0;
      rx_nbytes_i = '0;
      bd_rdata_i = '0;
      rx_buf_rdata_i = '0;
      arready_i = 1'b0;
      rvalid_i = 1'b0;
      rdata_i = '0;
      rlast_i = 1'b0;
      awready_i = 1'b0;
      wready_i = 1'b0;
      bd_raddr = '0;
      rxb_raddr = '0;
      rd_left = 0;
      wr_left = 0;
      r_taken = 1'b0;
      {ar_cnt, tx_irq_cnt, rx_irq_cnt, errors, tests} = '0;
      for (int i = 0; i < 256; i++) bd_mem[i] = '0;
      for (int i = 0; i < 65536; i++) amem[i] = 8'(i) ^ 8'(i >> 8) ^ 8'h3c;
      for (int i = 0; i < 2048; i++) rx_buf[i] = '0;
      @(negedge arst);
      test_preamble();
      test_tx_frame();
      test_tx_ring();
      test_rx_frame();
      test_concurrent();
      // Assertion failures of the bound checker count as errors too
      errors += dut_i.chk_i.fail_cnt;
      $display("%0d tests run, %0d errors", tests, errors);
      if (errors == 0) begin
         $display("all tests passed");
      end else begin
         $display("tests failed");
      end
      $finish;
   end

   // Watchdog for the whole run
   initial begin
      #2ms;
      $display("Run did not finish in time");
      $display("tests failed");
      $finish;
   end

endmodule

/* eth_dma_tx.sv */
`timescale 1ns/1ps
// Transmit DMA. Read bursts must not cross a 4 KB boundary, because this is not checked.
// After reset, 8 cycles write the preamble and SFD before the first BD is fetched.
module eth_dma_tx #(
   parameter int AXI_ADDR_W = 16,
   parameter int BD_ADDR_W  = 8,
   parameter int BUFFER_W   = 11
) (
   input  logic                               clk_i,
   input  logic                               arst_i,
   input  logic                               tx_en_i,
   input  logic                               tx_ready_i,
   input  logic [31:0]                        bd_rdata_i,
   bd_port_if.engine                          bd,
   output logic [AXI_ADDR_W-1:0]              araddr_o,
   output logic [eth_dma_pkg::AXI_LEN_W-1:0]  arlen_o,
   output logic                               arvalid_o,
   input  logic                               arready_i,
   input  logic                               rvalid_i,
   input  logic [eth_dma_pkg::AXI_DATA_W-1:0] rdata_i,
   input  logic                               rlast_i,
   output logic                               rready_o,
   output logic                               tx_buf_wen_o,
   output logic [BUFFER_W-1:0]                tx_buf_addr_o,
   output logic [7:0]                         tx_buf_wdata_o,
   output logic                               crc_en_o,
   output logic [eth_dma_pkg::NBYTES_W-1:0]   tx_nbytes_o,
   output logic                               send_o,
   output logic                               tx_irq_o
);

   localparam int NB_W = eth_dma_pkg::NBYTES_W;

   localparam logic [3:0] S_FILL     = 4'd0;
   localparam logic [3:0] S_BD_REQ   = 4'd1;
   localparam logic [3:0] S_BD_CHK   = 4'd2;
   localparam logic [3:0] S_PTR_REQ  = 4'd3;
   localparam logic [3:0] S_PTR_RD   = 4'd4;
   localparam logic [3:0] S_MAC_WAIT = 4'd5;
   localparam logic [3:0] S_FETCH    = 4'd6;
   localparam logic [3:0] S_AR       = 4'd7;
   localparam logic [3:0] S_RD       = 4'd8;
   localparam logic [3:0] S_SEND     = 4'd9;
   localparam logic [3:0] S_WB       = 4'd10;

   logic [3:0]              state_q;
   logic [BD_ADDR_W-2:0]    bd_num_q;
   logic [NB_W-1:0]         cnt_q;
   eth_dma_pkg::bd_status_u desc_q;
   eth_dma_pkg::bd_status_u rd_status;
   logic [AXI_ADDR_W-1:0]   ptr_q;
   logic [NB_W-1:0]         remaining;
   logic [1:0]              lane;
   logic                    fill;

   assign rd_status = bd_rdata_i;
   assign remaining = desc_q.tx.length[NB_W-1:0] - cnt_q;
   // Byte lane of the current address within the 32-bit beat
   assign lane      = ptr_q[1:0] + cnt_q[1:0];
   assign fill      = (state_q == S_FILL);

   // Word 0 holds status, word 1 holds the pointer
   assign bd.req   = (state_q == S_BD_REQ) || (state_q == S_PTR_REQ) || (state_q == S_WB);
   assign bd.addr  = {bd_num_q, state_q == S_PTR_REQ};
   assign bd.wen   = (state_q == S_WB);
   assign bd.wdata = desc_q;
   assign tx_irq_o = (state_q == S_WB) && bd.grant && desc_q.tx.irq;

   assign araddr_o  = ptr_q + AXI_ADDR_W'(cnt_q);
   assign arvalid_o = (state_q == S_AR);
   assign rready_o  = (state_q == S_RD);

   assign tx_buf_wen_o  = fill || (rready_o && rvalid_i);
   assign tx_buf_addr_o = fill ? BUFFER_W'(cnt_q) :
                          BUFFER_W'(eth_dma_pkg::PRE_FRAME_LEN + cnt_q);
   always_comb begin
      if (!fill) begin
         tx_buf_wdata_o = rdata_i[lane*8 +: 8];
      end else if (cnt_q == NB_W'(eth_dma_pkg::PREAMBLE_LEN)) begin
         tx_buf_wdata_o = eth_dma_pkg::SFD_BYTE;
      end else begin
         tx_buf_wdata_o = eth_dma_pkg::PREAMBLE_BYTE;
      end
   end

   always_ff @(posedge clk_i) begin
      if (arst_i) begin
         state_q  <= S_FILL;
         bd_num_q <= '0;
         cnt_q    <= '0;
         send_o   <= 1'b0;
      end else begin
         case (state_q)
            S_FILL: begin
               cnt_q <= cnt_q + 1'b1;
               if (cnt_q == NB_W'(eth_dma_pkg::PRE_FRAME_LEN - 1)) state_q <= S_BD_REQ;
            end
            S_BD_REQ: if (bd.grant) state_q <= S_BD_CHK;
            S_BD_CHK: begin
               desc_q  <= rd_status;
               state_q <= (rd_status.tx.ready && tx_en_i) ? S_PTR_REQ : S_BD_REQ;
            end
            S_PTR_REQ: if (bd.grant) state_q <= S_PTR_RD;
            S_PTR_RD: begin
               ptr_q   <= bd_rdata_i[AXI_ADDR_W-1:0];
               cnt_q   <= '0;
               state_q <= S_MAC_WAIT;
            end
            S_MAC_WAIT: if (tx_ready_i) state_q <= S_FETCH;
            S_FETCH: begin
               if (remaining == '0) begin
                  // Whole frame is in the buffer, hand it to the MAC
                  crc_en_o        <= desc_q.tx.crc_en;
                  tx_nbytes_o     <= desc_q.tx.length[NB_W-1:0] +
                                     NB_W'(eth_dma_pkg::PRE_FRAME_LEN);
                  desc_q.tx.ready <= 1'b0;
                  send_o          <= 1'b1;
                  state_q         <= S_SEND;
               end else begin
                  arlen_o <= eth_dma_pkg::burst_len(remaining);
                  state_q <= S_AR;
               end
            end
            S_AR: if (arready_i) state_q <= S_RD;
            S_RD: if (rvalid_i) begin
               cnt_q <= cnt_q + 1'b1;
               if (rlast_i) state_q <= S_FETCH;
            end
            // MAC drops tx_ready once it has taken the frame
            S_SEND: if (!tx_ready_i) begin
               send_o  <= 1'b0;
               state_q <= S_WB;
            end
            S_WB: if (bd.grant) begin
               bd_num_q <= (desc_q.tx.wrap || &bd_num_q) ? '0 : bd_num_q + 1'b1;
               state_q  <= S_BD_REQ;
            end
            default: state_q <= S_BD_REQ;
         endcase
      end
   end

endmodule

/* src.f */
eth_dma_pkg.sv
bd_port_if.sv
bd_arbiter.sv
eth_dma_tx.sv
eth_dma_rx.sv
eth_dma.sv
tb_clk_gen.sv
eth_dma_checker.sv
eth_dma_tb.sv

/* tb_clk_gen.sv */
`timescale 1ns/1ps
// Testbench clock of 10 ns, with reset held high for the first 4 rising edges
module tb_clk_gen (
   output logic clk_o,
   output logic arst_o
);

   initial begin
      clk_o = 1'b0;
      forever #5 clk_o = ~clk_o;
   end

   initial begin
      arst_o = 1'b1;
      repeat (4) @(posedge clk_o);
      @(negedge clk_o);
      arst_o = 1'b0;
   end

endmodule
